// ==== filelist.f ====
+incdir+source
+incdir+test
source/rv_decode_pkg.sv
source/op_classifier.sv
source/field_extractor.sv
source/decode_merge.sv
source/instr_decoder.sv
test/tb_instr_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the decoder testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

rm -rf "$OBJ" "$LOG"

verilator --binary --timing --assert \
   -f filelist.f \
   --top-module tb_instr_decoder \
   --Mdir "$OBJ" \
   -o tb_instr_decoder
status=$?
if [ $status -ne 0 ]; then
   echo "build failed with status $status"
   exit 1
fi

"./$OBJ/tb_instr_decoder" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "TEST PASSED" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== test/tb_decode_model.svh ====
`ifndef TB_DECODE_MODEL_SVH
`define TB_DECODE_MODEL_SVH

logic [31:0] rng_state = 32'hc514_477d;

// xorshift32
function automatic logic [31:0] next_rand();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

// legal encoding of a random operation, random fields elsewhere
function automatic logic [31:0] gen_legal();
   logic [31:0] w;
   logic [2:0]  f3;
   int          kind;
   int          idx;
   w    = next_rand();
   kind = int'(next_rand() % 9);
   idx  = int'(next_rand() % 6);
   f3   = w[14:12];
   case (kind)
      0: w[6:0] = `RV_OPC_LUI;
      1: w[6:0] = `RV_OPC_AUIPC;
      2: w[6:0] = `RV_OPC_JAL;
      3: begin
         w[6:0]   = `RV_OPC_JALR;
         w[14:12] = 3'b000;
      end
      4: begin
         w[6:0]   = `RV_OPC_BRANCH;
         w[14:12] = (idx < 2) ? 3'(idx) : 3'(idx + 2);
      end
      5: begin
         w[6:0]   = `RV_OPC_LOAD;
         idx      = idx % 5;
         w[14:12] = (idx < 3) ? 3'(idx) : 3'(idx + 1);
      end
      6: begin
         w[6:0]   = `RV_OPC_STORE;
         w[14:12] = 3'(idx % 3);
      end
      7: begin
         w[6:0] = `RV_OPC_OP_IMM;
         if (f3 == 3'b001)
            w[31:25] = 7'b0000000;
         else if (f3 == 3'b101)
            w[31:25] = idx[0] ? 7'b0100000 : 7'b0000000;
      end
      default: begin
         w[6:0]   = `RV_OPC_OP;
         w[31:25] = ((f3 == 3'b000 || f3 == 3'b101) && idx[0]) ? 7'b0100000 : 7'b0000000;
      end
   endcase
   return w;
endfunction

// reference decoder built from the RV32I opcode tables
function automatic void model_decode(input logic [31:0] w,
                                     output rv_decode_pkg::rv_op_e op,
                                     output rv_decode_pkg::inst_fmt_e fmt,
                                     output logic [4:0] rd,
                                     output logic [4:0] rs1,
                                     output logic [4:0] rs2,
                                     output logic [31:0] imm);
   logic [2:0] f3;
   logic [6:0] f7;
   f3  = w[14:12];
   f7  = w[31:25];
   op  = rv_decode_pkg::OP_ILLEGAL;
   fmt = rv_decode_pkg::FMT_NONE;
   case (w[6:0])
      `RV_OPC_LUI:   op = rv_decode_pkg::OP_LUI;
      `RV_OPC_AUIPC: op = rv_decode_pkg::OP_AUIPC;
      `RV_OPC_JAL:   op = rv_decode_pkg::OP_JAL;
      `RV_OPC_JALR:  if (f3 == 0) op = rv_decode_pkg::OP_JALR;
      `RV_OPC_BRANCH: begin
         if (f3 == 0) op = rv_decode_pkg::OP_BEQ;
         if (f3 == 1) op = rv_decode_pkg::OP_BNE;
         if (f3 == 4) op = rv_decode_pkg::OP_BLT;
         if (f3 == 5) op = rv_decode_pkg::OP_BGE;
         if (f3 == 6) op = rv_decode_pkg::OP_BLTU;
         if (f3 == 7) op = rv_decode_pkg::OP_BGEU;
      end
      `RV_OPC_LOAD: begin
         if (f3 == 0) op = rv_decode_pkg::OP_LB;
         if (f3 == 1) op = rv_decode_pkg::OP_LH;
         if (f3 == 2) op = rv_decode_pkg::OP_LW;
         if (f3 == 4) op = rv_decode_pkg::OP_LBU;
         if (f3 == 5) op = rv_decode_pkg::OP_LHU;
      end
      `RV_OPC_STORE: begin
         if (f3 == 0) op = rv_decode_pkg::OP_SB;
         if (f3 == 1) op = rv_decode_pkg::OP_SH;
         if (f3 == 2) op = rv_decode_pkg::OP_SW;
      end
      `RV_OPC_OP_IMM: begin
         if (f3 == 0) op = rv_decode_pkg::OP_ADDI;
         if (f3 == 2) op = rv_decode_pkg::OP_SLTI;
         if (f3 == 3) op = rv_decode_pkg::OP_SLTIU;
         if (f3 == 4) op = rv_decode_pkg::OP_XORI;
         if (f3 == 6) op = rv_decode_pkg::OP_ORI;
         if (f3 == 7) op = rv_decode_pkg::OP_ANDI;
         if (f3 == 1 && f7 == 7'h00) op = rv_decode_pkg::OP_SLLI;
         if (f3 == 5 && f7 == 7'h00) op = rv_decode_pkg::OP_SRLI;
         if (f3 == 5 && f7 == 7'h20) op = rv_decode_pkg::OP_SRAI;
      end
      `RV_OPC_OP: begin
         if (f7 == 7'h00) begin
            if (f3 == 0) op = rv_decode_pkg::OP_ADD;
            if (f3 == 1) op = rv_decode_pkg::OP_SLL;
            if (f3 == 2) op = rv_decode_pkg::OP_SLT;
            if (f3 == 3) op = rv_decode_pkg::OP_SLTU;
            if (f3 == 4) op = rv_decode_pkg::OP_XOR;
            if (f3 == 5) op = rv_decode_pkg::OP_SRL;
            if (f3 == 6) op = rv_decode_pkg::OP_OR;
            if (f3 == 7) op = rv_decode_pkg::OP_AND;
         end else if (f7 == 7'h20) begin
            if (f3 == 0) op = rv_decode_pkg::OP_SUB;
            if (f3 == 5) op = rv_decode_pkg::OP_SRA;
         end
      end
      default: op = rv_decode_pkg::OP_ILLEGAL;
   endcase
   if (op != rv_decode_pkg::OP_ILLEGAL) begin
      case (w[6:0])
         `RV_OPC_OP:                   fmt = rv_decode_pkg::FMT_R;
         `RV_OPC_STORE:                fmt = rv_decode_pkg::FMT_S;
         `RV_OPC_BRANCH:               fmt = rv_decode_pkg::FMT_B;
         `RV_OPC_LUI, `RV_OPC_AUIPC:   fmt = rv_decode_pkg::FMT_U;
         `RV_OPC_JAL:                  fmt = rv_decode_pkg::FMT_J;
         default:                      fmt = rv_decode_pkg::FMT_I;
      endcase
   end
   rd  = (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I,
                      rv_decode_pkg::FMT_U, rv_decode_pkg::FMT_J}) ? w[11:7] : 5'd0;
   rs1 = (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_I,
                      rv_decode_pkg::FMT_S, rv_decode_pkg::FMT_B}) ? w[19:15] : 5'd0;
   rs2 = (fmt inside {rv_decode_pkg::FMT_R, rv_decode_pkg::FMT_S,
                      rv_decode_pkg::FMT_B}) ? w[24:20] : 5'd0;
   // arithmetic shifts give the sign extension
   case (fmt)
      rv_decode_pkg::FMT_I: imm = 32'($signed(w) >>> 20);
      rv_decode_pkg::FMT_S: imm = 32'($signed({w[31:25], w[11:7], 20'd0}) >>> 20);
      rv_decode_pkg::FMT_B: imm = 32'($signed({w[31], w[7], w[30:25], w[11:8], 20'd0}) >>> 19);
      rv_decode_pkg::FMT_U: imm = {w[31:12], 12'd0};
      rv_decode_pkg::FMT_J: imm = 32'($signed({w[31], w[19:12], w[20], w[30:21], 12'd0}) >>> 11);
      default:              imm = 32'd0;
   endcase
endfunction

`endif

// ==== test/tb_instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module tb_instr_decoder;

   localparam int timeout_cycles = 50;

   logic                     clk;
   logic                     rst;
   logic [`RV_XLEN-1:0]      instr;
   logic                     in_req;
   logic                     in_ack;
   logic                     out_req;
   logic                     out_ack;
   rv_decode_pkg::rv_op_e    op;
   rv_decode_pkg::inst_fmt_e fmt;
   logic                     illegal;
   logic [`RV_REG_AW-1:0]    rd;
   logic [`RV_REG_AW-1:0]    rs1;
   logic [`RV_REG_AW-1:0]    rs2;
   logic [`RV_XLEN-1:0]      imm;

   int    errors = 0;
   int    checks = 0;
   int    tests_run = 0;
   int    errors_at_start = 0;
   string test_name = "";

   `include "tb_decode_model.svh"

   instr_decoder u_instr_decoder (
      .clk     (clk),
      .rst     (rst),
      .instr   (instr),
      .in_req  (in_req),
      .in_ack  (in_ack),
      .out_req (out_req),
      .out_ack (out_ack),
      .op      (op),
      .fmt     (fmt),
      .illegal (illegal),
      .rd      (rd),
      .rs1     (rs1),
      .rs2     (rs2),
      .imm     (imm)
   );

   always #4 clk = ~clk;

   task automatic report_error(input string msg);
      errors++;
      $display("%s: %s", test_name, msg);
   endtask

   task automatic check_op(input string what, input rv_decode_pkg::rv_op_e exp,
                           input rv_decode_pkg::rv_op_e act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s %s: expected %s, got %s", test_name, what, exp.name(), act.name());
      end
   endtask

   task automatic check_fmt(input string what, input rv_decode_pkg::inst_fmt_e exp,
                            input rv_decode_pkg::inst_fmt_e act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s %s: expected %s, got %s", test_name, what, exp.name(), act.name());
      end
   endtask

   task automatic check_field(input string what, input logic [`RV_REG_AW-1:0] exp,
                              input logic [`RV_REG_AW-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s %s: expected %0d, got %0d", test_name, what, exp, act);
      end
   endtask

   task automatic check_imm(input string what, input logic [`RV_XLEN-1:0] exp,
                            input logic [`RV_XLEN-1:0] act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s %s: expected %h, got %h", test_name, what, exp, act);
      end
   endtask

   task automatic check_flag(input string what, input logic exp, input logic act);
      checks++;
      if (exp !== act) begin
         errors++;
         $display("Fail %s %s: expected %b, got %b", test_name, what, exp, act);
      end
   endtask

   task automatic check_result(input logic [`RV_XLEN-1:0] w);
      rv_decode_pkg::rv_op_e    e_op;
      rv_decode_pkg::inst_fmt_e e_fmt;
      logic [`RV_REG_AW-1:0]    e_rd;
      logic [`RV_REG_AW-1:0]    e_rs1;
      logic [`RV_REG_AW-1:0]    e_rs2;
      logic [`RV_XLEN-1:0]      e_imm;
      model_decode(w, e_op, e_fmt, e_rd, e_rs1, e_rs2, e_imm);
      check_op($sformatf("op of %h", w), e_op, op);
      check_fmt($sformatf("fmt of %h", w), e_fmt, fmt);
      check_flag($sformatf("illegal of %h", w), e_op == rv_decode_pkg::OP_ILLEGAL, illegal);
      check_field($sformatf("rd of %h", w), e_rd, rd);
      check_field($sformatf("rs1 of %h", w), e_rs1, rs1);
      check_field($sformatf("rs2 of %h", w), e_rs2, rs2);
      check_imm($sformatf("imm of %h", w), e_imm, imm);
   endtask

   task automatic wait_in_ack(input logic level, output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (in_ack !== level && cycles < timeout_cycles);
      if (in_ack !== level)
         report_error($sformatf("timed out waiting for in_ack to go to %b", level));
   endtask

   task automatic wait_out_req(input logic level, output int cycles);
      cycles = 0;
      do begin
         @(posedge clk);
         #1;
         cycles++;
      end while (out_req !== level && cycles < timeout_cycles);
      if (out_req !== level)
         report_error($sformatf("timed out waiting for out_req to go to %b", level));
   endtask

   // in_req is already high, instr already driven
   task automatic accept_input(input logic [`RV_XLEN-1:0] w, input bit expect_fast);
      int cycles;
      wait_in_ack(1'b1, cycles);
      if (expect_fast && cycles != 1)
         report_error($sformatf("in_ack rose after %0d cycles instead of 1", cycles));
      if (!out_req)
         report_error("out_req did not rise together with in_ack");
      in_req = 1'b0;
      check_result(w);
      wait_in_ack(1'b0, cycles);
      if (cycles != 1)
         report_error($sformatf("in_ack fell after %0d cycles instead of 1", cycles));
   endtask

   task automatic release_output(input int hold, input bit queue_next,
                                 input logic [`RV_XLEN-1:0] w_next);
      logic [56:0] snap;
      int          cycles;
      snap = {op, fmt, illegal, rd, rs1, rs2, imm};
      if (queue_next) begin
         instr  = w_next;
         in_req = 1'b1;
      end
      for (int i = 0; i < hold; i++) begin
         @(posedge clk);
         #1;
         if (!out_req)
            report_error("out_req dropped while out_ack was withheld");
         if ({op, fmt, illegal, rd, rs1, rs2, imm} !== snap)
            report_error("held result changed while out_req was high");
         if (queue_next && in_ack)
            report_error("new request acknowledged while the output side was busy");
      end
      out_ack = 1'b1;
      wait_out_req(1'b0, cycles);
      if (cycles != 1)
         report_error($sformatf("out_req fell after %0d cycles instead of 1", cycles));
      if (queue_next && in_ack)
         report_error("new request acknowledged before out_ack returned low");
      if (queue_next) begin
         // out_ack still high, so the queued word has to wait
         @(posedge clk);
         #1;
         if (in_ack)
            report_error("new request acknowledged while out_ack was still high");
      end
      out_ack = 1'b0;
   endtask

   task automatic transfer(input logic [`RV_XLEN-1:0] w, input int hold);
      instr  = w;
      in_req = 1'b1;
      accept_input(w, 1'b1);
      release_output(hold, 1'b0, '0);
   endtask

   // producer keeps in_req high until the output side is done
   task automatic late_input_release(input logic [`RV_XLEN-1:0] w);
      int cycles;
      instr  = w;
      in_req = 1'b1;
      wait_in_ack(1'b1, cycles);
      if (cycles != 1)
         report_error($sformatf("in_ack rose after %0d cycles instead of 1", cycles));
      check_result(w);
      out_ack = 1'b1;
      wait_out_req(1'b0, cycles);
      out_ack = 1'b0;
      repeat (3) begin
         @(posedge clk);
         #1;
         if (out_req)
            report_error("second capture while in_ack was still high");
         if (!in_ack)
            report_error("in_ack dropped while in_req was still high");
      end
      in_req = 1'b0;
      wait_in_ack(1'b0, cycles);
      if (cycles != 1)
         report_error($sformatf("in_ack fell after %0d cycles instead of 1", cycles));
   endtask

   task automatic start_test(input string name);
      test_name       = name;
      errors_at_start = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors == errors_at_start)
         $display("test %s: ok", test_name);
      else
         $display("test %s: %0d errors", test_name, errors - errors_at_start);
   endtask

   initial begin
      logic [`RV_XLEN-1:0] bad_words [8];
      logic [`RV_XLEN-1:0] w2;
      clk     = 1'b0;
      rst     = 1'b1;
      instr   = '0;
      in_req  = 1'b0;
      out_ack = 1'b0;
      repeat (2) @(posedge clk);
      #1;
      rst = 1'b0;

      start_test("reset");
      check_flag("in_ack", 1'b0, in_ack);
      check_flag("out_req", 1'b0, out_req);
      check_op("op", rv_decode_pkg::rv_op_e'(6'd0), op);
      check_fmt("fmt", rv_decode_pkg::inst_fmt_e'(3'd0), fmt);
      check_flag("illegal", 1'b0, illegal);
      check_field("rd", '0, rd);
      check_field("rs1", '0, rs1);
      check_field("rs2", '0, rs2);
      check_imm("imm", '0, imm);
      end_test();

      start_test("legal_random");
      for (int i = 0; i < 300; i++)
         transfer(gen_legal(), 0);
      end_test();

      start_test("illegal");
      bad_words[0] = {7'b0000001, 5'd3, 5'd2, 3'b000, 5'd1, `RV_OPC_OP};
      bad_words[1] = {7'b0000001, 5'd7, 5'd6, 3'b101, 5'd5, `RV_OPC_OP};
      bad_words[2] = {7'b0100001, 5'd7, 5'd6, 3'b101, 5'd5, `RV_OPC_OP};
      bad_words[3] = {12'h7ff, 5'd9, 3'b011, 5'd4, `RV_OPC_LOAD};
      bad_words[4] = {25'h1abcdef, 7'b1111111};
      bad_words[5] = {25'h0012345, 7'b0001111};
      bad_words[6] = {25'h0000000, 7'b1110011};
      bad_words[7] = 32'h0000_0000;
      foreach (bad_words[i])
         transfer(bad_words[i], 0);
      // random words, mostly unknown opcodes
      for (int i = 0; i < 30; i++)
         transfer(next_rand(), 0);
      end_test();

      start_test("handshake");
      for (int i = 0; i < 20; i++)
         transfer(gen_legal(), 1 + int'(next_rand() % 3));
      for (int i = 0; i < 5; i++)
         late_input_release(gen_legal());
      end_test();

      start_test("backpressure");
      for (int i = 0; i < 20; i++) begin
         instr  = gen_legal();
         in_req = 1'b1;
         accept_input(instr, 1'b1);
         w2 = gen_legal();
         release_output(int'(next_rand() % 21), 1'b1, w2);
         accept_input(w2, 1'b0);
         release_output(int'(next_rand() % 21), 1'b0, '0);
      end
      end_test();

      $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
      if (errors == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module instr_decoder (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic [`RV_XLEN-1:0]      instr,
   input  wire logic                     in_req,
   output logic                          in_ack,
   output logic                          out_req,
   input  wire logic                     out_ack,
   output rv_decode_pkg::rv_op_e         op,
   output rv_decode_pkg::inst_fmt_e      fmt,
   output logic                          illegal,
   output logic      [`RV_REG_AW-1:0]    rd,
   output logic      [`RV_REG_AW-1:0]    rs1,
   output logic      [`RV_REG_AW-1:0]    rs2,
   output logic      [`RV_XLEN-1:0]      imm
);

   rv_decode_pkg::rv_op_e    cls_op;
   rv_decode_pkg::inst_fmt_e cls_fmt;
   logic                     cls_illegal;
   logic [`RV_REG_AW-1:0]    ext_rd;
   logic [`RV_REG_AW-1:0]    ext_rs1;
   logic [`RV_REG_AW-1:0]    ext_rs2;
   logic [`RV_XLEN-1:0]      ext_imm_i;
   logic [`RV_XLEN-1:0]      ext_imm_s;
   logic [`RV_XLEN-1:0]      ext_imm_b;
   logic [`RV_XLEN-1:0]      ext_imm_u;
   logic [`RV_XLEN-1:0]      ext_imm_j;

   op_classifier u_classifier (
      .instr   (instr),
      .op      (cls_op),
      .fmt     (cls_fmt),
      .illegal (cls_illegal)
   );

   field_extractor u_extractor (
      .instr (instr),
      .rd    (ext_rd),
      .rs1   (ext_rs1),
      .rs2   (ext_rs2),
      .imm_i (ext_imm_i),
      .imm_s (ext_imm_s),
      .imm_b (ext_imm_b),
      .imm_u (ext_imm_u),
      .imm_j (ext_imm_j)
   );

   decode_merge u_merge (
      .clk       (clk),
      .rst       (rst),
      .in_req    (in_req),
      .in_ack    (in_ack),
      .op        (cls_op),
      .fmt       (cls_fmt),
      .illegal   (cls_illegal),
      .rd_raw    (ext_rd),
      .rs1_raw   (ext_rs1),
      .rs2_raw   (ext_rs2),
      .imm_i     (ext_imm_i),
      .imm_s     (ext_imm_s),
      .imm_b     (ext_imm_b),
      .imm_u     (ext_imm_u),
      .imm_j     (ext_imm_j),
      .out_req   (out_req),
      .out_ack   (out_ack),
      .op_q      (op),
      .fmt_q     (fmt),
      .illegal_q (illegal),
      .rd_q      (rd),
      .rs1_q     (rs1),
      .rs2_q     (rs2),
      .imm_q     (imm)
   );

endmodule

`default_nettype wire

// ==== source/decode_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module decode_merge (
   input  wire logic                     clk,
   input  wire logic                     rst,
   input  wire logic                     in_req,
   output logic                          in_ack,
   input  wire rv_decode_pkg::rv_op_e    op,
   input  wire rv_decode_pkg::inst_fmt_e fmt,
   input  wire logic                     illegal,
   input  wire logic [`RV_REG_AW-1:0]    rd_raw,
   input  wire logic [`RV_REG_AW-1:0]    rs1_raw,
   input  wire logic [`RV_REG_AW-1:0]    rs2_raw,
   input  wire logic [`RV_XLEN-1:0]      imm_i,
   input  wire logic [`RV_XLEN-1:0]      imm_s,
   input  wire logic [`RV_XLEN-1:0]      imm_b,
   input  wire logic [`RV_XLEN-1:0]      imm_u,
   input  wire logic [`RV_XLEN-1:0]      imm_j,
   output logic                          out_req,
   input  wire logic                     out_ack,
   output rv_decode_pkg::rv_op_e         op_q,
   output rv_decode_pkg::inst_fmt_e      fmt_q,
   output logic                          illegal_q,
   output logic      [`RV_REG_AW-1:0]    rd_q,
   output logic      [`RV_REG_AW-1:0]    rs1_q,
   output logic      [`RV_REG_AW-1:0]    rs2_q,
   output logic      [`RV_XLEN-1:0]      imm_q
);

   logic                  idle;
   logic                  capture;
   logic                  keep_rd;
   logic                  keep_rs1;
   logic                  keep_rs2;
   logic [`RV_XLEN-1:0]   imm_sel;

   // both sides back at zero before the next word is taken
   assign idle    = !in_ack && !out_req && !out_ack;
   assign capture = idle && in_req;

   // FMT_NONE clears every field, which covers illegal words
   assign keep_rd  = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_I) ||
                     (fmt == rv_decode_pkg::FMT_U) || (fmt == rv_decode_pkg::FMT_J);
   assign keep_rs1 = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_I) ||
                     (fmt == rv_decode_pkg::FMT_S) || (fmt == rv_decode_pkg::FMT_B);
   assign keep_rs2 = (fmt == rv_decode_pkg::FMT_R) || (fmt == rv_decode_pkg::FMT_S) ||
                     (fmt == rv_decode_pkg::FMT_B);

   always_comb begin
      case (fmt)
         rv_decode_pkg::FMT_I: imm_sel = imm_i;
         rv_decode_pkg::FMT_S: imm_sel = imm_s;
         rv_decode_pkg::FMT_B: imm_sel = imm_b;
         rv_decode_pkg::FMT_U: imm_sel = imm_u;
         rv_decode_pkg::FMT_J: imm_sel = imm_j;
         default:              imm_sel = '0;
      endcase
   end

   // handshake controller
   always_ff @(posedge clk) begin
      if (rst) begin
         in_ack  <= 1'b0;
         out_req <= 1'b0;
      end else if (capture) begin
         in_ack  <= 1'b1;
         out_req <= 1'b1;
      end else begin
         if (in_ack && !in_req)
            in_ack <= 1'b0;
         if (out_req && out_ack)
            out_req <= 1'b0;
      end
   end

   // result register
   always_ff @(posedge clk) begin
      if (rst) begin
         op_q      <= rv_decode_pkg::rv_op_e'(6'd0);
         fmt_q     <= rv_decode_pkg::inst_fmt_e'(3'd0);
         illegal_q <= 1'b0;
         rd_q      <= '0;
         rs1_q     <= '0;
         rs2_q     <= '0;
         imm_q     <= '0;
      end else if (capture) begin
         op_q      <= op;
         fmt_q     <= fmt;
         illegal_q <= illegal;
         rd_q      <= keep_rd ? rd_raw : '0;
         rs1_q     <= keep_rs1 ? rs1_raw : '0;
         rs2_q     <= keep_rs2 ? rs2_raw : '0;
         imm_q     <= imm_sel;
      end
   end

   // out_req only drops after the consumer acknowledged
   out_req_held: assert property (@(posedge clk) disable iff (rst)
      out_req && !out_ack |=> out_req);

   result_stable: assert property (@(posedge clk) disable iff (rst)
      out_req |=> $stable({op_q, fmt_q, illegal_q, rd_q, rs1_q, rs2_q, imm_q}));

endmodule

`default_nettype wire

// ==== source/field_extractor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module field_extractor (
   input  wire logic [`RV_XLEN-1:0]   instr,
   output logic      [`RV_REG_AW-1:0] rd,
   output logic      [`RV_REG_AW-1:0] rs1,
   output logic      [`RV_REG_AW-1:0] rs2,
   output logic      [`RV_XLEN-1:0]   imm_i,
   output logic      [`RV_XLEN-1:0]   imm_s,
   output logic      [`RV_XLEN-1:0]   imm_b,
   output logic      [`RV_XLEN-1:0]   imm_u,
   output logic      [`RV_XLEN-1:0]   imm_j
);

   logic sign;

   assign sign = instr[31];

   // register fields sit at fixed positions in every format
   assign rd  = instr[11:7];
   assign rs1 = instr[19:15];
   assign rs2 = instr[24:20];

   assign imm_i = {{(`RV_XLEN-12){sign}}, instr[31:20]};

   assign imm_s = {{(`RV_XLEN-12){sign}}, instr[31:25], instr[11:7]};

   // bit 0 implied zero
   assign imm_b = {{(`RV_XLEN-13){sign}},
                   sign,
                   instr[7],
                   instr[30:25],
                   instr[11:8],
                   1'b0};

   // upper 20 bits, low 12 clear
   assign imm_u = {instr[31:12], 12'b0};

   assign imm_j = {{(`RV_XLEN-21){sign}},
                   sign,
                   instr[19:12],
                   instr[20],
                   instr[30:21],
                   1'b0};

endmodule

`default_nettype wire

// ==== source/op_classifier.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_decode_params.svh"

module op_classifier (
   input  wire logic [`RV_XLEN-1:0] instr,
   output rv_decode_pkg::rv_op_e    op,
   output rv_decode_pkg::inst_fmt_e fmt,
   output logic                     illegal
);

   logic [6:0]               opcode;
   logic [2:0]               funct3;
   logic [6:0]               funct7;
   logic                     f7_zero;
   logic                     f7_alt;
   logic                     enc_ok;
   rv_decode_pkg::inst_fmt_e fmt_raw;

   assign opcode  = instr[6:0];
   assign funct3  = instr[14:12];
   assign funct7  = instr[31:25];
   assign f7_zero = (funct7 == 7'b0000000);
   assign f7_alt  = (funct7 == 7'b0100000);

   // format depends on the major opcode only
   always_comb begin
      case (opcode)
         `RV_OPC_OP:     fmt_raw = rv_decode_pkg::FMT_R;
         `RV_OPC_OP_IMM: fmt_raw = rv_decode_pkg::FMT_I;
         `RV_OPC_LOAD:   fmt_raw = rv_decode_pkg::FMT_I;
         `RV_OPC_JALR:   fmt_raw = rv_decode_pkg::FMT_I;
         `RV_OPC_STORE:  fmt_raw = rv_decode_pkg::FMT_S;
         `RV_OPC_BRANCH: fmt_raw = rv_decode_pkg::FMT_B;
         `RV_OPC_LUI:    fmt_raw = rv_decode_pkg::FMT_U;
         `RV_OPC_AUIPC:  fmt_raw = rv_decode_pkg::FMT_U;
         `RV_OPC_JAL:    fmt_raw = rv_decode_pkg::FMT_J;
         default:        fmt_raw = rv_decode_pkg::FMT_NONE;
      endcase
   end

   // legality check, kept apart from the operation table
   always_comb begin
      case (opcode)
         `RV_OPC_LUI,
         `RV_OPC_AUIPC,
         `RV_OPC_JAL:    enc_ok = 1'b1;
         `RV_OPC_JALR:   enc_ok = (funct3 == 3'b000);
         `RV_OPC_BRANCH: enc_ok = (funct3[2:1] != 2'b01);
         `RV_OPC_LOAD:   enc_ok = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
         `RV_OPC_STORE:  enc_ok = (funct3 < 3'b011);
         `RV_OPC_OP_IMM: begin
            if (funct3 == 3'b001)
               enc_ok = f7_zero;
            else if (funct3 == 3'b101)
               enc_ok = f7_zero || f7_alt;
            else
               enc_ok = 1'b1;
         end
         `RV_OPC_OP:     enc_ok = f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101));
         default:        enc_ok = 1'b0;
      endcase
   end

   always_comb begin
      op = rv_decode_pkg::OP_ILLEGAL;
      case (opcode)
         `RV_OPC_LUI:   op = rv_decode_pkg::OP_LUI;
         `RV_OPC_AUIPC: op = rv_decode_pkg::OP_AUIPC;
         `RV_OPC_JAL:   op = rv_decode_pkg::OP_JAL;
         `RV_OPC_JALR: begin
            if (funct3 == 3'b000)
               op = rv_decode_pkg::OP_JALR;
         end
         `RV_OPC_BRANCH: begin
            case (funct3)
               3'b000:  op = rv_decode_pkg::OP_BEQ;
               3'b001:  op = rv_decode_pkg::OP_BNE;
               3'b100:  op = rv_decode_pkg::OP_BLT;
               3'b101:  op = rv_decode_pkg::OP_BGE;
               3'b110:  op = rv_decode_pkg::OP_BLTU;
               3'b111:  op = rv_decode_pkg::OP_BGEU;
               default: op = rv_decode_pkg::OP_ILLEGAL;
            endcase
         end
         `RV_OPC_LOAD: begin
            case (funct3)
               3'b000:  op = rv_decode_pkg::OP_LB;
               3'b001:  op = rv_decode_pkg::OP_LH;
               3'b010:  op = rv_decode_pkg::OP_LW;
               3'b100:  op = rv_decode_pkg::OP_LBU;
               3'b101:  op = rv_decode_pkg::OP_LHU;
               default: op = rv_decode_pkg::OP_ILLEGAL;
            endcase
         end
         `RV_OPC_STORE: begin
            case (funct3)
               3'b000:  op = rv_decode_pkg::OP_SB;
               3'b001:  op = rv_decode_pkg::OP_SH;
               3'b010:  op = rv_decode_pkg::OP_SW;
               default: op = rv_decode_pkg::OP_ILLEGAL;
            endcase
         end
         `RV_OPC_OP_IMM: begin
            case (funct3)
               3'b000: op = rv_decode_pkg::OP_ADDI;
               3'b010: op = rv_decode_pkg::OP_SLTI;
               3'b011: op = rv_decode_pkg::OP_SLTIU;
               3'b100: op = rv_decode_pkg::OP_XORI;
               3'b110: op = rv_decode_pkg::OP_ORI;
               3'b111: op = rv_decode_pkg::OP_ANDI;
               3'b001: begin
                  if (f7_zero)
                     op = rv_decode_pkg::OP_SLLI;
               end
               // srli and srai share funct3, funct7 splits them
               default: begin
                  if (f7_zero)
                     op = rv_decode_pkg::OP_SRLI;
                  else if (f7_alt)
                     op = rv_decode_pkg::OP_SRAI;
               end
            endcase
         end
         `RV_OPC_OP: begin
            case ({funct7, funct3})
               10'b0000000_000: op = rv_decode_pkg::OP_ADD;
               10'b0100000_000: op = rv_decode_pkg::OP_SUB;
               10'b0000000_001: op = rv_decode_pkg::OP_SLL;
               10'b0000000_010: op = rv_decode_pkg::OP_SLT;
               10'b0000000_011: op = rv_decode_pkg::OP_SLTU;
               10'b0000000_100: op = rv_decode_pkg::OP_XOR;
               10'b0000000_101: op = rv_decode_pkg::OP_SRL;
               10'b0100000_101: op = rv_decode_pkg::OP_SRA;
               10'b0000000_110: op = rv_decode_pkg::OP_OR;
               10'b0000000_111: op = rv_decode_pkg::OP_AND;
               default:         op = rv_decode_pkg::OP_ILLEGAL;
            endcase
         end
         default: op = rv_decode_pkg::OP_ILLEGAL;
      endcase
   end

   assign illegal = !enc_ok;
   assign fmt     = illegal ? rv_decode_pkg::FMT_NONE : fmt_raw;

   // legality table and operation table must agree
   always_comb begin
      assert (illegal == (op == rv_decode_pkg::OP_ILLEGAL))
         else $error("op_classifier: illegal flag disagrees with op for %h", instr);
   end

endmodule

`default_nettype wire

// ==== source/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

   // instruction format, FMT_NONE for anything illegal
   typedef enum logic [2:0] {
      FMT_R    = 3'd0,
      FMT_I    = 3'd1,
      FMT_S    = 3'd2,
      FMT_B    = 3'd3,
      FMT_U    = 3'd4,
      FMT_J    = 3'd5,
      FMT_NONE = 3'd6
   } inst_fmt_e;

   typedef enum logic [5:0] {
      OP_LUI     = 6'd0,
      OP_AUIPC,
      OP_JAL,
      OP_JALR,
      // branches
      OP_BEQ,
      OP_BNE,
      OP_BLT,
      OP_BGE,
      OP_BLTU,
      OP_BGEU,
      // loads and stores
      OP_LB,
      OP_LH,
      OP_LW,
      OP_LBU,
      OP_LHU,
      OP_SB,
      OP_SH,
      OP_SW,
      // immediate alu
      OP_ADDI,
      OP_SLTI,
      OP_SLTIU,
      OP_XORI,
      OP_ORI,
      OP_ANDI,
      OP_SLLI,
      OP_SRLI,
      OP_SRAI,
      // register alu
      OP_ADD,
      OP_SUB,
      OP_SLL,
      OP_SLT,
      OP_SLTU,
      OP_XOR,
      OP_OR,
      OP_AND,
      OP_SRL,
      OP_SRA,
      OP_ILLEGAL = 6'h3f
   } rv_op_e;

endpackage

`default_nettype wire

// ==== source/rv_decode_params.svh ====
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

// datapath widths
`define RV_XLEN   32
`define RV_REG_AW 5

// RV32I major opcodes, instr[6:0]
`define RV_OPC_LUI    7'b0110111
`define RV_OPC_AUIPC  7'b0010111
`define RV_OPC_JAL    7'b1101111
`define RV_OPC_JALR   7'b1100111
`define RV_OPC_BRANCH 7'b1100011
`define RV_OPC_LOAD   7'b0000011
`define RV_OPC_STORE  7'b0100011
`define RV_OPC_OP_IMM 7'b0010011
`define RV_OPC_OP     7'b0110011

`endif
